// ==== logic/if_pkg.sv ====
// ----------------------------
// instruction fetch stage package
// widths, fixed addresses, selector encodings and port structs
// ----------------------------

package if_pkg;

  // ----------------------------
  // widths
  // ----------------------------
  typedef logic [31:0] addr_t;       // byte address or pc
  typedef logic [31:0] instr_t;      // one instruction word
  typedef logic [23:0] trap_base_t;  // upper bits of a trap vector base
  typedef logic [4:0]  irq_id_t;     // vectored interrupt line

  localparam addr_t INSTR_BYTES  = 32'd4;         // sequential pc step
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800; // debug module halt entry

  // ----------------------------
  // selectors
  // ----------------------------
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_FENCEI    = 3'd1,
    PC_JUMP      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_EXCEPTION = 3'd4,
    PC_MRET      = 3'd5,
    PC_URET      = 3'd6,
    PC_DRET      = 3'd7
  } pc_sel_e;

  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'd0,
    EXC_PC_IRQ       = 3'd1,
    EXC_PC_DBD       = 3'd2
  } exc_pc_sel_e;

  typedef enum logic [0:0] {
    TRAP_MACHINE = 1'b0,
    TRAP_USER    = 1'b1
  } trap_sel_e;

  typedef enum logic [0:0] {
    IF_IDLE,  // nothing requested yet
    IF_WAIT   // serving the fetch stream
  } if_state_e;

  // ----------------------------
  // port structs
  // ----------------------------
  typedef struct packed {
    trap_base_t m_base;  // machine mode trap base
    trap_base_t u_base;  // user mode trap base
    trap_sel_e  sel;     // which base is live
  } trap_cfg_t;

  typedef struct packed {
    addr_t mepc;
    addr_t uepc;
    addr_t depc;
  } ret_addr_t;

  typedef struct packed {
    instr_t instr;
    addr_t  pc;
  } if_id_t;

endpackage

// ==== logic/pc_select.sv ====
// ----------------------------
// next pc selection
// builds the trap vector and picks the redirect target
// ----------------------------

`timescale 1ns/1ps

module pc_select import if_pkg::*; (
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_id_i,  // jal / jalr resolved in id
  input  addr_t       jump_target_ex_i,  // taken branch resolved in ex
  input  ret_addr_t   ret_addr_i,
  input  trap_cfg_t   trap_cfg_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     exc_vec_i,
  input  addr_t       pc_id_i,           // pc of the word sitting in id
  output addr_t       fetch_addr_n_o
);

  trap_base_t trap_base;
  addr_t      exc_pc;

  // machine or user trap base
  assign trap_base = (trap_cfg_i.sel == TRAP_USER) ? trap_cfg_i.u_base : trap_cfg_i.m_base;

  // ----------------------------
  // trap vector
  // ----------------------------
  always_comb begin
    exc_pc = {trap_base, 8'h00};  // all exceptions land on the base
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};
      EXC_PC_IRQ:       exc_pc = {trap_base, 1'b0, exc_vec_i, 2'b00}; // one slot per line
      EXC_PC_DBD:       exc_pc = DM_HALT_ADDR;
      default:          exc_pc = {trap_base, 8'h00};
    endcase
  end

  // ----------------------------
  // redirect target
  // ----------------------------
  always_comb begin
    fetch_addr_n_o = boot_addr_i;
    unique case (pc_mux_i)
      PC_BOOT:      fetch_addr_n_o = boot_addr_i;
      PC_FENCEI:    fetch_addr_n_o = pc_id_i + INSTR_BYTES; // refetch after the fence
      PC_JUMP:      fetch_addr_n_o = jump_target_id_i;
      PC_BRANCH:    fetch_addr_n_o = jump_target_ex_i;
      PC_EXCEPTION: fetch_addr_n_o = exc_pc;
      PC_MRET:      fetch_addr_n_o = ret_addr_i.mepc;
      PC_URET:      fetch_addr_n_o = ret_addr_i.uepc;
      PC_DRET:      fetch_addr_n_o = ret_addr_i.depc;
      default:      fetch_addr_n_o = boot_addr_i;
    endcase
  end

  // an unknown selector would send the core to a random target
  always_comb begin
    assert final (!$isunknown(pc_mux_i))
      else $error("pc_mux_i is unknown");
  end

endmodule

// ==== logic/fetch_unit.sv ====
// ----------------------------
// single word fetch unit
// one outstanding memory request, one held word with its pc,
// redirect discard and pmp stop
// ----------------------------

`timescale 1ns/1ps

module fetch_unit import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   branch_req_i,     // redirect to fetch_addr_n_i
  input  addr_t  fetch_addr_n_i,
  input  logic   fetch_ready_i,    // held word consumed
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_err_pmp_i,  // comes in place of a grant
  output logic   fetch_valid_o,
  output if_id_t fetch_o,
  output logic   fetch_failed_o,
  output logic   busy_o
);

  logic   req_q;        // request on the bus
  addr_t  addr_q;       // its address
  logic   owed_q;       // granted, rvalid still to come
  logic   drop_q;       // outstanding transaction belongs to an old stream
  logic   pend_q;       // redirect waiting for the bus
  addr_t  pend_addr_q;
  logic   hold_q;       // word_q is valid
  if_id_t word_q;
  logic   fail_q;       // pmp stop

  logic   granted;
  logic   req_keep;
  logic   owed_n;
  logic   bus_free;
  logic   redirect;
  addr_t  redir_addr;
  logic   launch;
  addr_t  launch_addr;
  logic   accept;

  // ----------------------------
  // bus bookkeeping
  // ----------------------------
  assign granted  = req_q & instr_gnt_i & ~instr_err_pmp_i;
  assign req_keep = req_q & ~instr_gnt_i & ~instr_err_pmp_i;  // still waiting for grant
  assign owed_n   = granted | (owed_q & ~instr_rvalid_i);
  assign bus_free = ~req_keep & ~owed_n;                      // nothing in flight after this edge

  // new request either from a redirect or the sequential step
  assign redirect    = branch_req_i | pend_q;
  assign redir_addr  = branch_req_i ? {fetch_addr_n_i[31:1], 1'b0} : pend_addr_q;
  assign launch      = bus_free & (redirect | (hold_q & fetch_ready_i));
  assign launch_addr = redirect ? redir_addr : word_q.pc + INSTR_BYTES;

  // keep the response unless it belongs to an old stream
  assign accept = owed_q & instr_rvalid_i & ~drop_q & ~branch_req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      addr_q <= '0;
      owed_q <= 1'b0;
      drop_q <= 1'b0;
      pend_q <= 1'b0;
      hold_q <= 1'b0;
      fail_q <= 1'b0;
    end else begin
      req_q  <= launch | req_keep;
      if (launch) addr_q <= launch_addr;
      owed_q <= owed_n;
      drop_q <= (branch_req_i | drop_q) & ~bus_free;  // lives until its transaction ends
      pend_q <= redirect & ~launch;
      hold_q <= accept | (hold_q & ~fetch_ready_i & ~branch_req_i);
      fail_q <= ~branch_req_i & (fail_q | (req_q & instr_err_pmp_i & ~drop_q));
    end
  end

  // payload qualified by pend_q / hold_q
  always_ff @(posedge clk) begin
    if (branch_req_i) pend_addr_q <= redir_addr;
    if (accept) begin
      word_q.instr <= instr_rdata_i;
      word_q.pc    <= addr_q;  // no new launch while a kept response is due
    end
  end

  assign instr_req_o    = req_q;
  assign instr_addr_o   = addr_q;
  assign fetch_valid_o  = hold_q;
  assign fetch_o        = word_q;
  assign fetch_failed_o = fail_q;
  assign busy_o         = req_q | owed_q;

  // ----------------------------
  // bus protocol checks
  // ----------------------------
  assert property (@(posedge clk) disable iff (!rst_n) instr_gnt_i |-> instr_req_o)
    else $error("grant without a request");

  // request and address hold until granted or refused by pmp
  assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i && !instr_err_pmp_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request dropped or address changed before grant");

endmodule

// ==== logic/if_ctrl.sv ====
// ----------------------------
// fetch control
// idle / wait machine deciding branch, ready and if valid
// ----------------------------

`timescale 1ns/1ps

module if_ctrl import if_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,
  input  logic pc_set_i,
  input  logic fetch_valid_i,
  input  logic halt_if_i,
  input  logic id_ready_i,
  output logic branch_req_o,
  output logic fetch_ready_o,
  output logic if_valid_o,
  output logic perf_imiss_o
);

  if_state_e state_q;
  if_state_e state_d;
  logic      valid;  // a word could go to id this cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IF_IDLE;
    else        state_q <= state_d;
  end

  always_comb begin
    state_d      = state_q;
    branch_req_o = 1'b0;
    valid        = 1'b0;
    unique case (state_q)
      IF_IDLE: begin
        if (req_i) begin  // first fetch starts from fetch_addr_n
          branch_req_o = 1'b1;
          state_d      = IF_WAIT;
        end
      end
      IF_WAIT: begin
        valid = fetch_valid_i;
      end
      default: state_d = IF_IDLE;
    endcase
    // redirect wins over everything
    if (pc_set_i) begin
      valid        = 1'b0;
      branch_req_o = 1'b1;
      state_d      = IF_WAIT;
    end
  end

  assign if_valid_o    = valid & id_ready_i & ~halt_if_i;
  assign fetch_ready_o = if_valid_o & req_i;  // release the held word
  assign perf_imiss_o  = ~fetch_valid_i | branch_req_o;

  // a redirect cycle never hands a word to id
  assert property (@(posedge clk) disable iff (!rst_n) pc_set_i |-> !if_valid_o)
    else $error("if_valid with pc_set");

endmodule

// ==== logic/if_id_regs.sv ====
// ----------------------------
// if/id pipeline register
// frozen while id stalls, tracks fetch failure on clear
// ----------------------------

`timescale 1ns/1ps

module if_id_regs import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   if_valid_i,           // word moves into id
  input  logic   clear_instr_valid_i,
  input  if_id_t fetch_i,
  input  logic   fetch_failed_i,
  output logic   instr_valid_id_o,
  output if_id_t if_id_o,
  output logic   is_fetch_failed_o
);

  // ----------------------------
  // control
  // ----------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o  <= 1'b0;
      is_fetch_failed_o <= 1'b0;
    end else if (if_valid_i) begin
      instr_valid_id_o  <= 1'b1;
      is_fetch_failed_o <= 1'b0;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o  <= 1'b0;
      is_fetch_failed_o <= fetch_failed_i;  // id sees the pmp stop as a bubble
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (if_valid_i) if_id_o <= fetch_i;
  end

  // a failed fetch is only flagged while the slot is empty
  assert property (@(posedge clk) disable iff (!rst_n)
    !(is_fetch_failed_o && instr_valid_id_o))
    else $error("fetch failure flagged with a valid instruction");

endmodule

// ==== logic/if_stage.sv ====
// ----------------------------
// instruction fetch stage top
// pc select, fetch unit, control and if/id register
// ----------------------------

`timescale 1ns/1ps

module if_stage import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  trap_cfg_t   trap_cfg_i,
  input  addr_t       boot_addr_i,
  input  logic        req_i,
  // ----------------------------
  // instruction memory
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_pmp_i,
  // ----------------------------
  // controller / id
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     exc_vec_i,
  input  ret_addr_t   ret_addr_i,
  input  addr_t       jump_target_id_i,
  input  addr_t       jump_target_ex_i,
  input  logic        halt_if_i,
  input  logic        id_ready_i,
  input  logic        clear_instr_valid_i,
  output logic        instr_valid_id_o,
  output if_id_t      if_id_o,
  output addr_t       pc_if_o,
  output logic        is_fetch_failed_o,
  output logic        if_busy_o,
  output logic        perf_imiss_o
);

  addr_t  fetch_addr_n;
  logic   branch_req;
  logic   fetch_ready;
  logic   fetch_valid;
  logic   fetch_failed;
  if_id_t fetch;
  logic   if_valid;

  pc_select i_pc_select (
    .boot_addr_i      (boot_addr_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .ret_addr_i       (ret_addr_i),
    .trap_cfg_i       (trap_cfg_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_vec_i        (exc_vec_i),
    .pc_id_i          (if_id_o.pc),  // fence.i restarts after the id word
    .fetch_addr_n_o   (fetch_addr_n)
  );

  fetch_unit i_fetch_unit (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_req_i    (branch_req),
    .fetch_addr_n_i  (fetch_addr_n),
    .fetch_ready_i   (fetch_ready),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .fetch_valid_o   (fetch_valid),
    .fetch_o         (fetch),
    .fetch_failed_o  (fetch_failed),
    .busy_o          (if_busy_o)
  );

  if_ctrl i_if_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .pc_set_i      (pc_set_i),
    .fetch_valid_i (fetch_valid),
    .halt_if_i     (halt_if_i),
    .id_ready_i    (id_ready_i),
    .branch_req_o  (branch_req),
    .fetch_ready_o (fetch_ready),
    .if_valid_o    (if_valid),
    .perf_imiss_o  (perf_imiss_o)
  );

  if_id_regs i_if_id_regs (
    .clk                 (clk),
    .rst_n               (rst_n),
    .if_valid_i          (if_valid),
    .clear_instr_valid_i (clear_instr_valid_i),
    .fetch_i             (fetch),
    .fetch_failed_i      (fetch_failed),
    .instr_valid_id_o    (instr_valid_id_o),
    .if_id_o             (if_id_o),
    .is_fetch_failed_o   (is_fetch_failed_o)
  );

  assign pc_if_o = fetch.pc;  // address of the held word

endmodule

// ==== test/if_tests.svh ====
// ----------------------------
// directed tests for the fetch stage
// expected pcs come from the redirect rules and the data pattern
// ----------------------------

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp)
    else begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// wait until the fetch unit holds a word
task automatic wait_for_word();
  int unsigned n;
  n = 0;
  @(negedge clk);
  while (perf_imiss_o) begin
    if (n == WAIT_LIMIT) stop_on_timeout("a fetched word");
    else begin
      n++;
      @(negedge clk);
    end
  end
endtask

// wait for a held word, then let id take exactly one
task automatic take_word(output if_id_t w);
  wait_for_word();
  @(posedge clk) id_ready_i <= 1'b1;
  @(posedge clk) id_ready_i <= 1'b0;
  @(negedge clk);
  check_value("instr_valid_id_o", instr_valid_id_o, 1'b1);
  w = if_id_o;
endtask

task automatic expect_word(input addr_t pc);
  if_id_t w;
  take_word(w);
  check_value("pc_id", w.pc, pc);
  check_value("instr", w.instr, pc ^ DATA_PATTERN);  // data follows its own address
  last_pc = w.pc;
endtask

task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc, input irq_id_t line);
  @(posedge clk);
  pc_set_i     <= 1'b1;
  pc_mux_i     <= sel;
  exc_pc_mux_i <= exc;
  exc_vec_i    <= line;
  @(posedge clk) pc_set_i <= 1'b0;
endtask

task automatic reset_status();
  @(negedge clk);
  check_value("instr_req_o", instr_req_o, 1'b0);
  check_value("instr_valid_id_o", instr_valid_id_o, 1'b0);
  check_value("is_fetch_failed_o", is_fetch_failed_o, 1'b0);
  check_value("if_busy_o", if_busy_o, 1'b0);
  check_value("perf_imiss_o", perf_imiss_o, 1'b1);  // nothing held yet
endtask

task automatic boot_sequence();
  @(posedge clk) req_i <= 1'b1;
  redirect(PC_BOOT, EXC_PC_EXCEPTION, '0);
  for (int i = 0; i < 10; i++) expect_word(boot_addr_i + 4 * i);
endtask

// each redirect comes right after a take, while the next word is usually owed
task automatic redirect_sources();
  addr_t fence_pc;
  redirect(PC_JUMP, EXC_PC_EXCEPTION, '0);
  expect_word(jump_target_id_i);
  expect_word(jump_target_id_i + 4);
  redirect(PC_BRANCH, EXC_PC_EXCEPTION, '0);
  expect_word(jump_target_ex_i);
  redirect(PC_MRET, EXC_PC_EXCEPTION, '0);
  expect_word(ret_addr_i.mepc);
  redirect(PC_URET, EXC_PC_EXCEPTION, '0);
  expect_word(ret_addr_i.uepc);
  redirect(PC_DRET, EXC_PC_EXCEPTION, '0);
  expect_word(ret_addr_i.depc);
  fence_pc = last_pc + 4;
  redirect(PC_FENCEI, EXC_PC_EXCEPTION, '0);
  expect_word(fence_pc);
endtask

task automatic trap_vectors();
  irq_id_t line;
  line = irq_id_t'($urandom_range(0, 31));
  redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, '0);
  expect_word({trap_cfg_i.m_base, 8'h00});
  @(posedge clk) trap_cfg_i.sel <= TRAP_USER;
  redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, '0);
  expect_word({trap_cfg_i.u_base, 8'h00});
  @(posedge clk) trap_cfg_i.sel <= TRAP_MACHINE;
  redirect(PC_EXCEPTION, EXC_PC_IRQ, line);
  expect_word({trap_cfg_i.m_base, 1'b0, line, 2'b00});
  redirect(PC_EXCEPTION, EXC_PC_DBD, '0);
  expect_word(DM_HALT_ADDR);
endtask

task automatic back_pressure();
  addr_t next_pc;
  next_pc = last_pc + 4;
  wait_for_word();  // next word parked in the fetch unit
  repeat (4) begin  // id stalled
    @(negedge clk);
    check_value("pc_id under stall", if_id_o.pc, last_pc);
    check_value("instr_id under stall", if_id_o.instr, last_pc ^ DATA_PATTERN);
    check_value("pc_if under stall", pc_if_o, next_pc);
    check_value("instr_req_o under stall", instr_req_o, 1'b0);
  end
  @(posedge clk) begin
    halt_if_i  <= 1'b1;
    id_ready_i <= 1'b1;
  end
  repeat (4) begin
    @(negedge clk);
    check_value("pc_id under halt", if_id_o.pc, last_pc);
    check_value("instr_valid_id_o under halt", instr_valid_id_o, 1'b1);
    check_value("pc_if under halt", pc_if_o, next_pc);
    check_value("instr_req_o under halt", instr_req_o, 1'b0);
  end
  @(posedge clk) begin
    halt_if_i  <= 1'b0;
    id_ready_i <= 1'b0;
  end
  expect_word(next_pc);  // nothing skipped or repeated
  expect_word(next_pc + 4);
  @(posedge clk) clear_instr_valid_i <= 1'b1;
  @(posedge clk) clear_instr_valid_i <= 1'b0;
  @(negedge clk);
  check_value("instr_valid_id_o after clear", instr_valid_id_o, 1'b0);
  check_value("is_fetch_failed_o after clear", is_fetch_failed_o, 1'b0);
endtask

task automatic pmp_failure();
  int unsigned n;
  addr_t       base;
  base = 32'h0000_9000;
  pmp_addr  = base + 8;
  pmp_armed = 1'b1;
  @(posedge clk) jump_target_id_i <= base;
  redirect(PC_JUMP, EXC_PC_EXCEPTION, '0);
  expect_word(base);
  expect_word(base + 4);
  n = 0;
  while (if_busy_o) begin
    if (n == WAIT_LIMIT) stop_on_timeout("the refused fetch to settle");
    else begin
      n++;
      @(negedge clk);
    end
  end
  repeat (6) begin  // fetch stopped so no word shows up at the refused pc
    @(negedge clk);
    check_value("perf_imiss_o after pmp stop", perf_imiss_o, 1'b1);
    check_value("instr_req_o after pmp stop", instr_req_o, 1'b0);
  end
  @(posedge clk) clear_instr_valid_i <= 1'b1;
  @(posedge clk) clear_instr_valid_i <= 1'b0;
  @(negedge clk);
  check_value("is_fetch_failed_o", is_fetch_failed_o, 1'b1);
  check_value("instr_valid_id_o", instr_valid_id_o, 1'b0);
  pmp_armed = 1'b0;
  @(posedge clk) jump_target_id_i <= 32'h0000_a000;
  redirect(PC_JUMP, EXC_PC_EXCEPTION, '0);
  expect_word(32'h0000_a000);
  check_value("is_fetch_failed_o after resume", is_fetch_failed_o, 1'b0);
  expect_word(32'h0000_a004);
endtask

// ==== test/tb_if_stage.sv ====
// ----------------------------
// testbench for the fetch stage
// clock, reset, memory model with random latency
// ----------------------------

`timescale 1ns/1ps

module tb_if_stage import if_pkg::*; ();

  localparam time         PERIOD       = 40ns;
  localparam int unsigned SEED         = 32'hf16a3329;
  localparam int unsigned WAIT_LIMIT   = 200;           // cycles per wait loop
  localparam instr_t      DATA_PATTERN = 32'h5a5a_0000;

  logic clk = 1'b0;
  logic rst_n;
  trap_cfg_t trap_cfg_i;
  addr_t boot_addr_i, jump_target_id_i, jump_target_ex_i;
  logic req_i, pc_set_i, halt_if_i, id_ready_i, clear_instr_valid_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t exc_vec_i;
  ret_addr_t ret_addr_i;
  logic instr_req_o;
  logic instr_gnt_i     = 1'b0;
  logic instr_rvalid_i  = 1'b0;
  logic instr_err_pmp_i = 1'b0;
  addr_t instr_addr_o, pc_if_o;
  instr_t instr_rdata_i = '0;
  logic instr_valid_id_o, is_fetch_failed_o, if_busy_o, perf_imiss_o;
  if_id_t if_id_o;

  int unsigned error_count = 0;
  logic        pmp_armed = 1'b0;  // model answers pmp_addr with an error
  addr_t       pmp_addr  = '0;
  addr_t       last_pc;           // pc of the last word taken into id

  int unsigned gnt_wait, rv_wait;
  logic        waiting, rv_pend;
  addr_t       rv_addr;

  always #(PERIOD/2) clk = ~clk;

  if_stage i_dut (.*);

  // ----------------------------
  // instruction memory model
  // ----------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_gnt_i     <= 1'b0;
      instr_err_pmp_i <= 1'b0;
      instr_rvalid_i  <= 1'b0;
      instr_rdata_i   <= '0;
      waiting = 1'b0;
      rv_pend = 1'b0;
    end else begin
      instr_rvalid_i <= 1'b0;
      if (rv_pend) begin
        if (rv_wait == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= rv_addr ^ DATA_PATTERN;
          rv_pend = 1'b0;
        end else begin
          rv_wait--;
        end
      end
      if (instr_req_o && (instr_gnt_i || instr_err_pmp_i)) begin  // accepted at this edge
        instr_gnt_i     <= 1'b0;
        instr_err_pmp_i <= 1'b0;
        waiting = 1'b0;
        if (instr_gnt_i) begin
          rv_pend = 1'b1;
          rv_wait = $urandom_range(0, 2);  // rvalid 1..3 cycles later
          rv_addr = instr_addr_o;
        end
      end else if (instr_req_o) begin
        if (!waiting) begin
          waiting  = 1'b1;
          gnt_wait = $urandom_range(0, 3);
        end
        if (gnt_wait != 0) gnt_wait--;
        else if (pmp_armed && instr_addr_o == pmp_addr) instr_err_pmp_i <= 1'b1;
        else instr_gnt_i <= 1'b1;
      end
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t ns", what, $time);
    $display("Summary: %0d errors, 1 timeout", error_count);
    $display("Test failures found");
    $finish;
  endtask

  `include "if_tests.svh"

  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    trap_cfg_i = '{m_base: 24'h000_010, u_base: 24'h000_020, sel: TRAP_MACHINE};
    boot_addr_i = 32'h0000_0080;
    jump_target_id_i = 32'h0000_4000;
    jump_target_ex_i = 32'h0000_5010;
    ret_addr_i = '{mepc: 32'h0000_6000, uepc: 32'h0000_7004, depc: 32'h0000_8008};
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    exc_vec_i = '0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b0;
    clear_instr_valid_i = 1'b0;
    last_pc = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_status();
    boot_sequence();
    redirect_sources();
    trap_vectors();
    back_pressure();
    pmp_failure();
    $display("Summary: %0d errors, 0 timeouts", error_count);
    if (error_count == 0) $display("All tests passed!");
    else $display("Test failures found");
    $finish;
  end

endmodule

// ==== if_stage.f ====
logic/if_pkg.sv
logic/pc_select.sv
logic/fetch_unit.sv
logic/if_ctrl.sv
logic/if_id_regs.sv
logic/if_stage.sv
+incdir+test
test/tb_if_stage.sv

// ==== Bender.yml ====
package:
  name: if_stage

sources:
  - files:
      - logic/if_pkg.sv
      - logic/pc_select.sv
      - logic/fetch_unit.sv
      - logic/if_ctrl.sv
      - logic/if_id_regs.sv
      - logic/if_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_if_stage.sv
